// ==== rtl/hash_map_settings.svh ====
// Key, data and memory size macros and the CRC polynomial of the hash map
`ifndef HASH_MAP_SETTINGS_SVH
`define HASH_MAP_SETTINGS_SVH

// Key and data widths
`define HM_KEY_BITS 32
`define HM_DAT_BITS 8

// Collision memory, one head node per hash index
`define HM_HASH_SIZE 8
`define HM_HASH_BITS 3

// Linked-list memory, pointer 0 terminates a chain
`define HM_LL_SIZE 8
`define HM_LL_BITS 3

// CRC-32, no reflection
`define HM_CRC_POLY 32'h04C11DB7

`endif

// ==== rtl/hash_map_pkg.sv ====
// Opcode enum and the pointer, node, request and response types of the hash map
`include "hash_map_settings.svh"

package hash_map_pkg;

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_ADD    = 2'd1,
    OP_DELETE = 2'd2
  } opcode_t;

  typedef logic [`HM_LL_BITS-1:0] ll_ptr_t;

  // Word stored in both the collision and the linked-list memory
  typedef struct packed {
    logic [`HM_KEY_BITS-1:0] key;
    logic [`HM_DAT_BITS-1:0] dat;
    ll_ptr_t                 nxt_ptr;
    logic                    used;
  } hm_node_t;

  typedef struct packed {
    opcode_t                 opcode;
    logic [`HM_KEY_BITS-1:0] key;
    logic [`HM_DAT_BITS-1:0] dat;
  } hm_req_t;

  // dat is the value the key held before the request, zero when not found
  typedef struct packed {
    logic                    fnd;
    logic [`HM_DAT_BITS-1:0] dat;
  } hm_rsp_t;

endpackage

// ==== rtl/crc_hash.sv ====
// Combinational CRC-32 of the key, reduced to a collision-memory index
`include "hash_map_settings.svh"

module crc_hash (
  input  logic [`HM_KEY_BITS-1:0]  i_key,
  output logic [`HM_HASH_BITS-1:0] o_index
);

  logic [31:0] crc;

  // Bit-serial CRC unrolled over the key, MSB first, starting from zero
  always_comb begin
    crc = '0;
    for (int i = `HM_KEY_BITS - 1; i >= 0; i--) begin
      if (crc[31] ^ i_key[i]) begin
        crc = {crc[30:0], 1'b0} ^ `HM_CRC_POLY;
      end else begin
        crc = {crc[30:0], 1'b0};
      end
    end
  end

  // Low bits pick the head entry
  assign o_index = crc[`HM_HASH_BITS-1:0];

endmodule

// ==== rtl/node_ram.sv ====
// Single-port node memory with a registered read port
module node_ram #(
  parameter int DEPTH = 8
) (
  input  logic                       i_clk,
  input  logic [$clog2(DEPTH)-1:0]   i_addr,
  input  logic                       i_we,
  input  hash_map_pkg::hm_node_t     i_wr_node,
  output hash_map_pkg::hm_node_t     o_rd_node
);
  import hash_map_pkg::*;

  hm_node_t mem [DEPTH];

  // Read returns the old word when a write hits the same address
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wr_node;
    end
    o_rd_node <= mem[i_addr];
  end

endmodule

// ==== rtl/free_ptr_fifo.sv ====
// Circular FIFO of free linked-list pointers with self reload of pointers 1 and up
`include "hash_map_settings.svh"

module free_ptr_fifo (
  input  logic                  i_clk,
  input  logic                  coll_ram_rst,
  input  logic                  i_reload,
  output logic                  o_loaded,
  input  logic                  i_push,
  input  hash_map_pkg::ll_ptr_t i_push_ptr,
  input  logic                  i_pop,
  output hash_map_pkg::ll_ptr_t o_head_ptr,
  output logic                  o_empty
);
  import hash_map_pkg::*;

  ll_ptr_t              ptr_mem [`HM_LL_SIZE];
  ll_ptr_t              rd_idx, wr_idx, fill_ptr, wr_ptr;
  logic [`HM_LL_BITS:0] count;
  logic                 filling, wr_en, rd_en;

  // Reload filling takes the write port ahead of pushes
  assign wr_en      = filling || i_push;
  assign wr_ptr     = filling ? fill_ptr : i_push_ptr;
  assign rd_en      = i_pop && !o_empty;
  assign o_head_ptr = ptr_mem[rd_idx];
  assign o_empty    = (count == '0);

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst) begin
      rd_idx   <= '0;
      wr_idx   <= '0;
      count    <= '0;
      fill_ptr <= ll_ptr_t'(1);
      filling  <= 1'b0;
      o_loaded <= 1'b0;
    end else if (i_reload) begin
      rd_idx   <= '0;
      wr_idx   <= '0;
      count    <= '0;
      fill_ptr <= ll_ptr_t'(1);
      filling  <= 1'b1;
      o_loaded <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (rd_en) begin
        rd_idx <= rd_idx + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Pointer 0 is skipped so it stays the chain terminator
      if (filling) begin
        fill_ptr <= fill_ptr + 1'b1;
        if (fill_ptr == `HM_LL_BITS'(`HM_LL_SIZE - 1)) begin
          filling  <= 1'b0;
          o_loaded <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      ptr_mem[wr_idx] <= wr_ptr;
    end
  end

endmodule

// ==== rtl/hash_map_ctrl.sv ====
// Hash map FSM for initialization, lookup, add and delete with chain walking
`include "hash_map_settings.svh"

module hash_map_ctrl (
  input  logic                     i_clk,
  input  logic                     coll_ram_rst,
  input  hash_map_pkg::hm_req_t    i_req,
  input  logic                     i_val,
  output logic                     o_rdy,
  output hash_map_pkg::hm_rsp_t    o_rsp,
  output logic                     o_val,
  input  logic                     i_cfg_clr,
  output logic                     o_cfg_full,
  output logic [`HM_KEY_BITS-1:0]  o_key,
  input  logic [`HM_HASH_BITS-1:0] i_index,
  output logic [`HM_HASH_BITS-1:0] o_coll_addr,
  output logic                     o_coll_we,
  output hash_map_pkg::hm_node_t   o_coll_wr,
  input  hash_map_pkg::hm_node_t   i_coll_rd,
  output hash_map_pkg::ll_ptr_t    o_ll_addr,
  output logic                     o_ll_we,
  output hash_map_pkg::hm_node_t   o_ll_wr,
  input  hash_map_pkg::hm_node_t   i_ll_rd,
  output logic                     o_fifo_reload,
  input  logic                     i_fifo_loaded,
  output logic                     o_fifo_push,
  output hash_map_pkg::ll_ptr_t    o_fifo_push_ptr,
  output logic                     o_fifo_pop,
  input  hash_map_pkg::ll_ptr_t    i_fifo_head,
  input  logic                     i_fifo_empty
);
  import hash_map_pkg::*;

  typedef enum logic [2:0] {INIT, IDLE, SCAN_HEAD, SCAN_LIST, RELINK} state_t;

  state_t                   state, state_d;
  logic                     rdy_q, rdy_d, val_q, val_d, full_q;
  logic                     ll_wait, ll_wait_d, init_first, init_first_d;
  logic                     clr_done, clr_done_d;
  logic [`HM_HASH_BITS-1:0] clr_idx, clr_idx_d, head_idx, head_idx_d;
  hm_req_t                  req_q, req_d;
  hm_rsp_t                  rsp_q, rsp_d;
  ll_ptr_t                  cur_ptr, cur_ptr_d, prev_ptr, prev_ptr_d, link_ptr, link_ptr_d;
  logic                     prev_head, prev_head_d, head_copy, head_copy_d;
  logic                     done, head_hit, list_hit, is_add, is_del;
  hm_node_t                 new_node;

  assign o_key           = i_req.key;
  assign o_rdy           = rdy_q;
  assign o_val           = val_q;
  assign o_rsp           = rsp_q;
  assign o_cfg_full      = full_q;
  assign o_fifo_reload   = (state == INIT) && init_first;
  assign o_fifo_push_ptr = cur_ptr;

  assign is_add   = (req_q.opcode == OP_ADD);
  assign is_del   = (req_q.opcode == OP_DELETE);
  assign head_hit = i_coll_rd.used && (i_coll_rd.key == req_q.key);
  assign list_hit = i_ll_rd.used && (i_ll_rd.key == req_q.key);
  assign new_node = '{key: req_q.key, dat: req_q.dat, nxt_ptr: '0, used: 1'b1};

  always_comb begin
    state_d      = state;
    rdy_d        = rdy_q;
    val_d        = 1'b0;
    ll_wait_d    = 1'b1;
    init_first_d = 1'b0;
    clr_idx_d    = clr_idx;
    clr_done_d   = clr_done;
    req_d        = req_q;
    rsp_d        = rsp_q;
    head_idx_d   = head_idx;
    cur_ptr_d    = cur_ptr;
    prev_ptr_d   = prev_ptr;
    prev_head_d  = prev_head;
    link_ptr_d   = link_ptr;
    head_copy_d  = head_copy;
    done         = 1'b0;
    o_coll_addr  = head_idx;
    o_coll_we    = 1'b0;
    o_coll_wr    = i_coll_rd;
    o_ll_addr    = cur_ptr;
    o_ll_we      = 1'b0;
    o_ll_wr      = i_ll_rd;
    o_fifo_push  = 1'b0;
    o_fifo_pop   = 1'b0;

    case (state)
      INIT: begin
        // One collision entry cleared per cycle while the FIFO refills
        o_coll_addr = clr_idx;
        o_coll_we   = !clr_done;
        o_coll_wr   = '0;
        if (!clr_done) begin
          clr_idx_d  = clr_idx + 1'b1;
          clr_done_d = (clr_idx == `HM_HASH_BITS'(`HM_HASH_SIZE - 1));
        end
        if (clr_done && i_fifo_loaded && !init_first) begin
          state_d = IDLE;
          rdy_d   = 1'b1;
        end
      end
      IDLE: begin
        // Head read issued at the hash of the incoming key
        o_coll_addr = i_index;
        if (rdy_q && i_val) begin
          req_d      = i_req;
          head_idx_d = i_index;
          rdy_d      = 1'b0;
          state_d    = SCAN_HEAD;
        end
      end
      SCAN_HEAD: begin
        rsp_d = '{fnd: head_hit, dat: head_hit ? i_coll_rd.dat : '0};
        if (!i_coll_rd.used) begin
          done      = 1'b1;
          o_coll_we = is_add;
          o_coll_wr = new_node;
        end else if (head_hit && is_del && (i_coll_rd.nxt_ptr != '0)) begin
          // Successor is copied over the head in RELINK
          cur_ptr_d   = i_coll_rd.nxt_ptr;
          head_copy_d = 1'b1;
          state_d     = RELINK;
        end else if (head_hit) begin
          done      = 1'b1;
          o_coll_we = is_add || is_del;
          if (is_del) begin
            o_coll_wr = '0;
          end else begin
            o_coll_wr.dat = req_q.dat;
          end
        end else if (i_coll_rd.nxt_ptr != '0) begin
          cur_ptr_d   = i_coll_rd.nxt_ptr;
          prev_head_d = 1'b1;
          head_copy_d = 1'b0;
          state_d     = SCAN_LIST;
        end else begin
          // Head is the tail, new node and head link written together
          done = 1'b1;
          if (is_add && !i_fifo_empty) begin
            o_fifo_pop        = 1'b1;
            o_ll_addr         = i_fifo_head;
            o_ll_we           = 1'b1;
            o_ll_wr           = new_node;
            o_coll_we         = 1'b1;
            o_coll_wr.nxt_ptr = i_fifo_head;
          end
        end
      end
      SCAN_LIST: begin
        // Every list node takes a wait cycle and a decision cycle
        ll_wait_d = !ll_wait;
        if (!ll_wait) begin
          rsp_d = '{fnd: list_hit, dat: list_hit ? i_ll_rd.dat : '0};
          if (list_hit && is_del) begin
            link_ptr_d = i_ll_rd.nxt_ptr;
            state_d    = RELINK;
          end else if (list_hit) begin
            done        = 1'b1;
            o_ll_we     = is_add;
            o_ll_wr.dat = req_q.dat;
          end else if (i_ll_rd.nxt_ptr != '0) begin
            prev_ptr_d  = cur_ptr;
            prev_head_d = 1'b0;
            cur_ptr_d   = i_ll_rd.nxt_ptr;
          end else if (is_add && !i_fifo_empty) begin
            // New node stored now, old tail linked to it in RELINK
            o_fifo_pop  = 1'b1;
            o_ll_addr   = i_fifo_head;
            o_ll_we     = 1'b1;
            o_ll_wr     = new_node;
            link_ptr_d  = i_fifo_head;
            prev_ptr_d  = cur_ptr;
            prev_head_d = 1'b0;
            state_d     = RELINK;
          end else begin
            done = 1'b1;
          end
        end
      end
      RELINK: begin
        ll_wait_d = !ll_wait;
        o_ll_addr = head_copy ? cur_ptr : prev_ptr;
        if (!ll_wait) begin
          done        = 1'b1;
          o_fifo_push = is_del;
          if (head_copy) begin
            o_coll_we = 1'b1;
            o_coll_wr = i_ll_rd;
          end else if (prev_head) begin
            o_coll_we         = 1'b1;
            o_coll_wr.nxt_ptr = link_ptr;
          end else begin
            o_ll_we         = 1'b1;
            o_ll_wr.nxt_ptr = link_ptr;
          end
        end
      end
      default: state_d = INIT;
    endcase

    if (done) begin
      state_d = IDLE;
      rdy_d   = 1'b1;
      val_d   = 1'b1;
    end

    // Clear restarts initialization from any state
    if (i_cfg_clr) begin
      state_d      = INIT;
      rdy_d        = 1'b0;
      val_d        = 1'b0;
      init_first_d = 1'b1;
      clr_idx_d    = '0;
      clr_done_d   = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!coll_ram_rst) begin
      state      <= INIT;
      rdy_q      <= 1'b0;
      val_q      <= 1'b0;
      full_q     <= 1'b0;
      ll_wait    <= 1'b1;
      init_first <= 1'b1;
      clr_idx    <= '0;
      clr_done   <= 1'b0;
    end else begin
      state      <= state_d;
      rdy_q      <= rdy_d;
      val_q      <= val_d;
      full_q     <= (state_d != INIT) && i_fifo_empty;
      ll_wait    <= ll_wait_d;
      init_first <= init_first_d;
      clr_idx    <= clr_idx_d;
      clr_done   <= clr_done_d;
    end
  end

  always_ff @(posedge i_clk) begin
    req_q     <= req_d;
    rsp_q     <= rsp_d;
    head_idx  <= head_idx_d;
    cur_ptr   <= cur_ptr_d;
    prev_ptr  <= prev_ptr_d;
    prev_head <= prev_head_d;
    link_ptr  <= link_ptr_d;
    head_copy <= head_copy_d;
  end

endmodule

// ==== rtl/hash_map.sv ====
// Hash map top level joining controller, CRC hash, both node memories and pointer FIFO
`include "hash_map_settings.svh"

module hash_map (
  input  logic                  i_clk,
  input  logic                  coll_ram_rst,
  input  hash_map_pkg::hm_req_t i_req,
  input  logic                  i_val,
  output logic                  o_rdy,
  output hash_map_pkg::hm_rsp_t o_rsp,
  output logic                  o_val,
  input  logic                  i_cfg_clr,
  output logic                  o_cfg_full
);
  import hash_map_pkg::*;

  logic [`HM_KEY_BITS-1:0]  key;
  logic [`HM_HASH_BITS-1:0] index, coll_addr;
  logic                     coll_we, ll_we;
  hm_node_t                 coll_wr, coll_rd, ll_wr, ll_rd;
  ll_ptr_t                  ll_addr, push_ptr, head_ptr;
  logic                     fifo_reload, fifo_loaded, fifo_push, fifo_pop, fifo_empty;

  hash_map_ctrl u_ctrl (
    .i_clk           (i_clk),
    .coll_ram_rst    (coll_ram_rst),
    .i_req           (i_req),
    .i_val           (i_val),
    .o_rdy           (o_rdy),
    .o_rsp           (o_rsp),
    .o_val           (o_val),
    .i_cfg_clr       (i_cfg_clr),
    .o_cfg_full      (o_cfg_full),
    .o_key           (key),
    .i_index         (index),
    .o_coll_addr     (coll_addr),
    .o_coll_we       (coll_we),
    .o_coll_wr       (coll_wr),
    .i_coll_rd       (coll_rd),
    .o_ll_addr       (ll_addr),
    .o_ll_we         (ll_we),
    .o_ll_wr         (ll_wr),
    .i_ll_rd         (ll_rd),
    .o_fifo_reload   (fifo_reload),
    .i_fifo_loaded   (fifo_loaded),
    .o_fifo_push     (fifo_push),
    .o_fifo_push_ptr (push_ptr),
    .o_fifo_pop      (fifo_pop),
    .i_fifo_head     (head_ptr),
    .i_fifo_empty    (fifo_empty)
  );

  crc_hash u_crc_hash (
    .i_key   (key),
    .o_index (index)
  );

  // Head node of each hash index
  node_ram #(.DEPTH(`HM_HASH_SIZE)) u_coll_ram (
    .i_clk     (i_clk),
    .i_addr    (coll_addr),
    .i_we      (coll_we),
    .i_wr_node (coll_wr),
    .o_rd_node (coll_rd)
  );

  // Colliding nodes, chained through nxt_ptr
  node_ram #(.DEPTH(`HM_LL_SIZE)) u_ll_ram (
    .i_clk     (i_clk),
    .i_addr    (ll_addr),
    .i_we      (ll_we),
    .i_wr_node (ll_wr),
    .o_rd_node (ll_rd)
  );

  free_ptr_fifo u_free_ptr_fifo (
    .i_clk        (i_clk),
    .coll_ram_rst (coll_ram_rst),
    .i_reload     (fifo_reload),
    .o_loaded     (fifo_loaded),
    .i_push       (fifo_push),
    .i_push_ptr   (push_ptr),
    .i_pop        (fifo_pop),
    .o_head_ptr   (head_ptr),
    .o_empty      (fifo_empty)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and synchronous active-low reset generator
module tb_clock_gen #(
  parameter int HALF_PERIOD = 4,
  parameter int RST_CYCLES  = 4
) (
  output logic o_clk,
  output logic coll_ram_rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // Reset low for RST_CYCLES rising edges, released on a falling edge
  initial begin
    coll_ram_rst = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    coll_ram_rst = 1'b1;
  end

endmodule

// ==== testbench/hash_map_tb.sv ====
// Hash map testbench with reference CRC, map model, response checker and watchdog
`include "hash_map_settings.svh"

module hash_map_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import hash_map_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_REQ    = 200;
  // Worst case of head, every list node, relink and the gap before the next request
  localparam int MAX_LAT    = 3 + 2 * `HM_LL_SIZE + 2 + 4;
  localparam int INIT_CYC   = 4 * (`HM_HASH_SIZE + `HM_LL_SIZE + 4);
  localparam int TIMEOUT_NS = (MAX_REQ * MAX_LAT + INIT_CYC) * CLK_PERIOD;

  logic    clk, coll_ram_rst;
  hm_req_t req;
  logic    req_val, rdy, rsp_val, cfg_clr, cfg_full;
  hm_rsp_t rsp;
  integer  seed;

  // Expected responses in request order
  hm_rsp_t                 exp_q [$];
  bit [`HM_DAT_BITS-1:0]   model_dat [bit [`HM_KEY_BITS-1:0]];
  int                      idx_cnt [`HM_HASH_SIZE];
  bit [`HM_KEY_BITS-1:0]   used_keys [$];

  tb_clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RST_CYCLES(4)) u_clock_gen (
    .o_clk        (clk),
    .coll_ram_rst (coll_ram_rst)
  );

  hash_map UUT (
    .i_clk        (clk),
    .coll_ram_rst (coll_ram_rst),
    .i_req        (req),
    .i_val        (req_val),
    .o_rdy        (rdy),
    .o_rsp        (rsp),
    .o_val        (rsp_val),
    .i_cfg_clr    (cfg_clr),
    .o_cfg_full   (cfg_full)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Remainder of key * x^32 divided by the CRC polynomial
  function automatic int ref_index(input bit [`HM_KEY_BITS-1:0] key);
    bit [63:0] rem;
    rem = {key, 32'h0};
    for (int i = 63; i >= 32; i--) begin
      if (rem[i]) begin
        rem = rem ^ ({31'h0, 1'b1, `HM_CRC_POLY} << (i - 32));
      end
    end
    return int'(rem[`HM_HASH_BITS-1:0]);
  endfunction

  function automatic bit [`HM_KEY_BITS-1:0] key_for_index(input int idx);
    bit [`HM_KEY_BITS-1:0] key;
    do begin
      key = $random(seed);
    end while (ref_index(key) != idx);
    return key;
  endfunction

  function automatic bit [`HM_DAT_BITS-1:0] rand_dat();
    integer r;
    r = $random(seed);
    return r[`HM_DAT_BITS-1:0];
  endfunction

  // Every key beyond the first in an index occupies one list node
  function automatic int list_nodes_used();
    int n;
    n = 0;
    foreach (idx_cnt[i]) begin
      if (idx_cnt[i] > 1) begin
        n += idx_cnt[i] - 1;
      end
    end
    return n;
  endfunction

  function automatic bit model_full();
    return list_nodes_used() == `HM_LL_SIZE - 1;
  endfunction

  // Expected response of a request, which also updates the model
  function automatic hm_rsp_t model_step(input hm_req_t r);
    hm_rsp_t exp_rsp;
    int      idx;
    exp_rsp = '0;
    idx     = ref_index(r.key);
    if (model_dat.exists(r.key)) begin
      exp_rsp.fnd = 1'b1;
      exp_rsp.dat = model_dat[r.key];
    end
    if (r.opcode == OP_ADD) begin
      if (exp_rsp.fnd) begin
        model_dat[r.key] = r.dat;
      end else if (idx_cnt[idx] == 0 || list_nodes_used() < `HM_LL_SIZE - 1) begin
        model_dat[r.key] = r.dat;
        idx_cnt[idx]++;
      end
    end else if (r.opcode == OP_DELETE && exp_rsp.fnd) begin
      model_dat.delete(r.key);
      idx_cnt[idx]--;
    end
    return exp_rsp;
  endfunction

  task automatic send(input opcode_t op, input bit [`HM_KEY_BITS-1:0] key,
                      input bit [`HM_DAT_BITS-1:0] dat);
    hm_req_t r;
    r.opcode = op;
    r.key    = key;
    r.dat    = dat;
    while (!rdy) @(negedge clk);
    exp_q.push_back(model_step(r));
    req     = r;
    req_val = 1'b1;
    @(negedge clk);
    req_val = 1'b0;
    assert (!rdy)
      else fail_run($sformatf("Error at time %0t: o_rdy still high after a request", $time));
    while (!rsp_val) @(negedge clk);
    // Full flag follows the FIFO one cycle after the response
    @(negedge clk);
    assert (cfg_full == model_full())
      else fail_run($sformatf("Error at time %0t: o_cfg_full is %0b, expected %0b",
                              $time, cfg_full, model_full()));
  endtask

  task automatic lookup_all();
    foreach (used_keys[i]) begin
      send(OP_LOOKUP, used_keys[i], 8'h00);
    end
  endtask

  task automatic clear_map();
    cfg_clr = 1'b1;
    @(negedge clk);
    cfg_clr = 1'b0;
    model_dat.delete();
    foreach (idx_cnt[i]) idx_cnt[i] = 0;
    while (!rdy) @(negedge clk);
    assert (!cfg_full)
      else fail_run($sformatf("Error at time %0t: o_cfg_full high after clear", $time));
  endtask

  always @(negedge clk) begin : compare_rsp
    hm_rsp_t exp_rsp;
    if (rsp_val) begin
      assert (exp_q.size() != 0)
        else fail_run("A response arrived with no request outstanding");
      exp_rsp = exp_q.pop_front();
      assert (rsp == exp_rsp)
        else fail_run($sformatf(
          "Error at time %0t: got fnd=%0b dat=%02h, expected fnd=%0b dat=%02h",
          $time, rsp.fnd, rsp.dat, exp_rsp.fnd, exp_rsp.dat));
      assert (rdy)
        else fail_run($sformatf("Error at time %0t: o_rdy low during o_val", $time));
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    fail_run("Timeout: the DUT stopped responding before the tests finished");
  end

  initial begin
    bit [`HM_KEY_BITS-1:0] k;
    bit [`HM_KEY_BITS-1:0] chain [$];
    bit [`HM_KEY_BITS-1:0] full_keys [$];
    int                    r;
    seed    = 32'he05e5e31;
    req     = '0;
    req_val = 1'b0;
    cfg_clr = 1'b0;
    foreach (idx_cnt[i]) idx_cnt[i] = 0;
    @(negedge clk);
    assert (!rdy && !rsp_val && !cfg_full)
      else fail_run($sformatf("Error at time %0t: outputs high during reset", $time));
    wait (coll_ram_rst === 1'b1);
    while (!rdy) @(negedge clk);
    assert (!cfg_full)
      else fail_run($sformatf("Error at time %0t: o_cfg_full high after reset", $time));

    // Empty map lookups
    repeat (8) send(OP_LOOKUP, $random(seed), 8'h00);

    // One key per index and then an overwrite with new data
    for (int i = 0; i < 4; i++) begin
      k = key_for_index(i);
      used_keys.push_back(k);
      send(OP_ADD, k, rand_dat());
    end
    lookup_all();
    send(OP_ADD, used_keys[0], ~model_dat[used_keys[0]]);
    send(OP_LOOKUP, used_keys[0], 8'h00);

    // Chain of colliding keys at index 5
    for (int i = 0; i < 5; i++) begin
      chain.push_back(key_for_index(5));
      used_keys.push_back(chain[i]);
    end
    for (int i = 0; i < 4; i++) send(OP_ADD, chain[i], rand_dat());
    lookup_all();

    // Lone head, head with successor, list node after list node, list node after head
    send(OP_DELETE, used_keys[0], 8'h00);
    send(OP_ADD, chain[4], rand_dat());
    send(OP_DELETE, chain[0], 8'h00);
    send(OP_DELETE, chain[3], 8'h00);
    send(OP_DELETE, chain[2], 8'h00);
    send(OP_DELETE, chain[0], 8'h00);
    lookup_all();

    // Exhaust the list nodes through index 6
    for (int i = 0; i < 10; i++) begin
      full_keys.push_back(key_for_index(6));
      used_keys.push_back(full_keys[i]);
      send(OP_ADD, full_keys[i], rand_dat());
    end
    assert (cfg_full)
      else fail_run($sformatf("Error at time %0t: o_cfg_full low with no free node", $time));
    send(OP_ADD, chain[2], rand_dat());
    lookup_all();
    send(OP_DELETE, full_keys[1], 8'h00);
    send(OP_ADD, chain[2], rand_dat());

    // Clear empties the map
    clear_map();
    lookup_all();

    // Random mix over the key pool
    repeat (40) begin
      r = $unsigned($random(seed)) % 3;
      k = used_keys[$unsigned($random(seed)) % used_keys.size()];
      case (r)
        0:       send(OP_LOOKUP, k, 8'h00);
        1:       send(OP_ADD, k, rand_dat());
        default: send(OP_DELETE, k, 8'h00);
      endcase
    end

    repeat (2) @(negedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/hash_map_pkg.sv
rtl/crc_hash.sv
rtl/node_ram.sv
rtl/free_ptr_fifo.sv
rtl/hash_map_ctrl.sv
rtl/hash_map.sv
testbench/tb_clock_gen.sv
testbench/hash_map_tb.sv

// ==== Makefile ====
# Verilator build and run of the hash map testbench

VERILATOR ?= verilator
TOP       ?= hash_map_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation run succeeded"; \
	else \
		echo "Simulation run did not succeed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
